// File: src.f
source/ooo_types_pkg.sv
source/phys_reg_file.sv
source/dispatch_stage.sv
source/alu_unit.sv
source/mul_unit.sv
source/ooo_backend_top.sv
sim/ooo_backend_assertions.sv
sim/tb_ooo_backend.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ooo_backend -f src.f \
    && ./obj_dir/Vtb_ooo_backend | tee sim.log \
    || echo "Build or simulation ended with an error"
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/tb_ooo_backend.sv
// Back-end directed testbench

`timescale 1ns/1ps

module tb_ooo_backend;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 60;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST + 100)
                                     * CLK_PERIOD;

    logic                         clk;
    logic                         rst;
    ooo_types_pkg::dispatch_req_t dispatch_req;
    logic                         dispatch_busy;
    ooo_types_pkg::cdb_t          cdb;

    ooo_types_pkg::word_t     ref_val [64];
    ooo_types_pkg::cdb_slot_t alu_seen [$];
    ooo_types_pkg::cdb_slot_t mul_seen [$];
    int                       alu_when [$];
    int                       mul_when [$];
    ooo_types_pkg::rob_id_t   next_rob;
    int                       cycle = 0;
    int                       errors;

    ooo_backend_top #(
        .NUM_PHYS_REGS (64),
        .MUL_STAGES    (3)
    ) u_ooo_backend_top (
        .clk           (clk),
        .rst           (rst),
        .dispatch_req  (dispatch_req),
        .dispatch_busy (dispatch_busy),
        .cdb           (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Every broadcast is logged with the number of edges seen so far
    always @(negedge clk) begin
        if (!rst && cdb.alu_slot.valid) begin
            alu_seen.push_back(cdb.alu_slot);
            alu_when.push_back(cycle);
        end
        if (!rst && cdb.mul_slot.valid) begin
            mul_seen.push_back(cdb.mul_slot);
            mul_when.push_back(cycle);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    function automatic ooo_types_pkg::word_t model_op(
        input ooo_types_pkg::op_t   op,
        input ooo_types_pkg::word_t a,
        input ooo_types_pkg::word_t b
    );
        logic [63:0] wide;
        wide = {32'h0, a} * {32'h0, b};
        case (op)
            ooo_types_pkg::OP_ADD: return a + b;
            ooo_types_pkg::OP_SUB: return a - b;
            ooo_types_pkg::OP_AND: return a & b;
            ooo_types_pkg::OP_XOR: return a ^ b;
            ooo_types_pkg::OP_LI:  return b;
            default:               return wide[31:0];
        endcase
    endfunction

    task automatic compare_slot(
        input string                    name,
        input ooo_types_pkg::cdb_slot_t got,
        input ooo_types_pkg::cdb_slot_t exp
    );
        if (got !== exp) begin
            $display("[FAIL] %s got valid=%h rd=%h rob_id=%h value=%h", name,
                     got.valid, got.rd, got.rob_id, got.value);
            $display("[FAIL] %s exp valid=%h rd=%h rob_id=%h value=%h", name,
                     exp.valid, exp.rd, exp.rob_id, exp.value);
            errors++;
        end
    endtask

    task automatic compare_busy(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Holds the request for one accepting edge and updates the model in program order
    task automatic send(
        input  ooo_types_pkg::op_t       op,
        input  ooo_types_pkg::phys_tag_t rs1,
        input  ooo_types_pkg::phys_tag_t rs2,
        input  ooo_types_pkg::phys_tag_t rd,
        input  ooo_types_pkg::word_t     imm,
        output ooo_types_pkg::cdb_slot_t expected,
        output int                       accepted
    );
        ooo_types_pkg::word_t b;
        while (dispatch_busy) begin
            @(posedge clk);
            #2;
        end
        b = (op == ooo_types_pkg::OP_LI) ? imm : ref_val[rs2];
        expected = '{1'b1, rd, next_rob, model_op(op, ref_val[rs1], b)};
        dispatch_req = '{1'b1, op, rs1, rs2, rd, next_rob, imm};
        @(posedge clk);
        #2;
        accepted = cycle;
        dispatch_req.valid = 1'b0;
        next_rob = next_rob + 3'd1;
        ref_val[rd] = expected.value;
    endtask

    // Takes the next broadcast of one unit and checks its latency unless it is negative
    task automatic expect_result(
        input  bit                       from_mul,
        input  ooo_types_pkg::cdb_slot_t expected,
        input  int                       accepted,
        input  int                       latency,
        output int                       when
    );
        ooo_types_pkg::cdb_slot_t got;
        int waited = 0;
        while (((from_mul ? mul_seen.size() : alu_seen.size()) == 0) && (waited < 20)) begin
            @(posedge clk);
            #2;
            waited++;
        end
        when = -1;
        if (from_mul && mul_seen.size() > 0) begin
            got  = mul_seen.pop_front();
            when = mul_when.pop_front();
        end else if (!from_mul && alu_seen.size() > 0) begin
            got  = alu_seen.pop_front();
            when = alu_when.pop_front();
        end else begin
            $display("No %s result for rd %0d arrived within 20 cycles",
                     from_mul ? "MUL" : "ALU", expected.rd);
            errors++;
            return;
        end
        compare_slot(from_mul ? "cdb.mul_slot" : "cdb.alu_slot", got, expected);
        if (latency >= 0 && (when - accepted) != latency) begin
            $display("Result for rd %0d came %0d cycles after acceptance instead of %0d",
                     expected.rd, when - accepted, latency);
            errors++;
        end
    endtask

    task automatic load(input ooo_types_pkg::phys_tag_t tag, input ooo_types_pkg::word_t val);
        ooo_types_pkg::cdb_slot_t expected;
        int                       accepted;
        int                       when;
        send(ooo_types_pkg::OP_LI, 6'd0, 6'd0, tag, val, expected, accepted);
        expect_result(1'b0, expected, accepted, 2, when);
    endtask

    // Idle outputs after reset and an add of two untouched tags giving zero
    task automatic test_reset_state();
        ooo_types_pkg::cdb_slot_t expected;
        int                       accepted;
        int                       when;
        compare_busy("dispatch_busy", dispatch_busy, 1'b0);
        compare_slot("cdb.alu_slot", cdb.alu_slot, '0);
        send(ooo_types_pkg::OP_ADD, 6'd30, 6'd31, 6'd32, '0, expected, accepted);
        expect_result(1'b0, expected, accepted, 2, when);
    endtask

    task automatic test_alu_ops();
        ooo_types_pkg::op_t       ops [4];
        ooo_types_pkg::cdb_slot_t expected;
        int                       accepted;
        int                       when;
        ops = '{ooo_types_pkg::OP_ADD, ooo_types_pkg::OP_SUB, ooo_types_pkg::OP_AND,
                ooo_types_pkg::OP_XOR};
        load(6'd1, $urandom());
        load(6'd2, $urandom());
        for (int i = 0; i < 4; i++) begin
            send(ops[i], 6'd1, 6'd2, 6'(3 + i), '0, expected, accepted);
            expect_result(1'b0, expected, accepted, 2, when);
        end
    endtask

    task automatic test_mul_pipeline();
        ooo_types_pkg::cdb_slot_t expected [3];
        int                       accepted [3];
        int                       when;
        load(6'd4, $urandom());
        load(6'd5, $urandom());
        load(6'd6, $urandom());
        send(ooo_types_pkg::OP_MUL, 6'd4, 6'd5, 6'd10, '0, expected[0], accepted[0]);
        send(ooo_types_pkg::OP_MUL, 6'd5, 6'd6, 6'd11, '0, expected[1], accepted[1]);
        send(ooo_types_pkg::OP_MUL, 6'd4, 6'd6, 6'd12, '0, expected[2], accepted[2]);
        for (int i = 0; i < 3; i++) begin
            expect_result(1'b1, expected[i], accepted[0], 4 + i, when);
        end
    endtask

    task automatic test_dependent_chain();
        ooo_types_pkg::cdb_slot_t mul_exp;
        ooo_types_pkg::cdb_slot_t add_exp;
        int                       mul_acc;
        int                       add_acc;
        int                       mul_when;
        int                       add_when;
        send(ooo_types_pkg::OP_MUL, 6'd4, 6'd5, 6'd13, '0, mul_exp, mul_acc);
        compare_busy("dispatch_busy", dispatch_busy, 1'b0);
        send(ooo_types_pkg::OP_ADD, 6'd13, 6'd4, 6'd14, '0, add_exp, add_acc);
        // ADD sits in the hold register waiting for the product
        compare_busy("dispatch_busy", dispatch_busy, 1'b1);
        expect_result(1'b1, mul_exp, mul_acc, 4, mul_when);
        expect_result(1'b0, add_exp, add_acc, -1, add_when);
        if (add_when >= 0 && add_when <= mul_when) begin
            $display("Dependent ADD broadcast before the MUL it depends on");
            errors++;
        end
    endtask

    // ADD reads tag 15 in the cycle the LI result for it is on the bus
    task automatic test_transparency();
        ooo_types_pkg::cdb_slot_t expected [3];
        int                       accepted [3];
        int                       when;
        send(ooo_types_pkg::OP_LI, 6'd0, 6'd0, 6'd15, $urandom(), expected[0], accepted[0]);
        send(ooo_types_pkg::OP_LI, 6'd0, 6'd0, 6'd16, $urandom(), expected[1], accepted[1]);
        send(ooo_types_pkg::OP_ADD, 6'd15, 6'd4, 6'd17, '0, expected[2], accepted[2]);
        if (accepted[2] != accepted[0] + 2) begin
            $display("ADD was not accepted alongside the LI broadcast");
            errors++;
        end
        for (int i = 0; i < 3; i++) begin
            expect_result(1'b0, expected[i], accepted[i], 2, when);
        end
    endtask

    task automatic test_rename_guard();
        ooo_types_pkg::cdb_slot_t expected [4];
        int                       accepted [4];
        int                       when;
        send(ooo_types_pkg::OP_MUL, 6'd4, 6'd5, 6'd20, '0, expected[0], accepted[0]);
        send(ooo_types_pkg::OP_MUL, 6'd5, 6'd6, 6'd20, '0, expected[1], accepted[1]);
        send(ooo_types_pkg::OP_XOR, 6'd20, 6'd4, 6'd21, '0, expected[2], accepted[2]);
        expect_result(1'b1, expected[0], accepted[0], 4, when);
        expect_result(1'b1, expected[1], accepted[1], 4, when);
        expect_result(1'b0, expected[2], accepted[2], -1, when);
        // Stored value of tag 20 must be the newer product
        send(ooo_types_pkg::OP_ADD, 6'd20, 6'd0, 6'd22, '0, expected[3], accepted[3]);
        expect_result(1'b0, expected[3], accepted[3], 2, when);
    endtask

    task automatic test_tag_zero();
        ooo_types_pkg::cdb_slot_t expected;
        int                       accepted;
        int                       when;
        send(ooo_types_pkg::OP_ADD, 6'd0, 6'd4, 6'd23, '0, expected, accepted);
        expect_result(1'b0, expected, accepted, 2, when);
        send(ooo_types_pkg::OP_SUB, 6'd4, 6'd0, 6'd24, '0, expected, accepted);
        expect_result(1'b0, expected, accepted, 2, when);
        send(ooo_types_pkg::OP_MUL, 6'd0, 6'd5, 6'd25, '0, expected, accepted);
        expect_result(1'b1, expected, accepted, 4, when);
    endtask

    initial begin
        void'($urandom(51708));
        errors       = 0;
        next_rob     = '0;
        dispatch_req = '0;
        rst          = 1'b1;
        foreach (ref_val[i]) begin
            ref_val[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_state();
        test_alu_ops();
        test_mul_pipeline();
        test_dependent_chain();
        test_transparency();
        test_rename_guard();
        test_tag_zero();
        repeat (8) @(posedge clk);
        if (alu_seen.size() != 0 || mul_seen.size() != 0) begin
            $display("Unexpected broadcasts left over at the end of the run");
            errors++;
        end
        $display("Checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: sim/ooo_backend_assertions.sv
// Dispatch and CDB assertions

`timescale 1ns/1ps

module ooo_backend_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     busy,
    input ooo_types_pkg::exec_req_t alu_req,
    input ooo_types_pkg::cdb_t      cdb
);

    // An issued ALU request broadcasts on the next edge
    alu_issue: assert property (@(posedge clk) disable iff (rst)
        alu_req.valid |=> (cdb.alu_slot.valid && (cdb.alu_slot.rd == $past(alu_req.rd))))
        else $error("ALU request did not reach the ALU slot one cycle later");

    busy_after_reset: assert property (@(posedge clk) rst |=> !busy)
        else $error("Dispatch busy in the cycle after reset");

    // Tag 0 is never a destination
    alu_slot_rd: assert property (@(posedge clk) disable iff (rst)
        cdb.alu_slot.valid |-> (cdb.alu_slot.rd != '0))
        else $error("ALU slot valid with rd zero");

    mul_slot_rd: assert property (@(posedge clk) disable iff (rst)
        cdb.mul_slot.valid |-> (cdb.mul_slot.rd != '0))
        else $error("MUL slot valid with rd zero");

endmodule

bind dispatch_stage ooo_backend_assertions u_ooo_backend_assertions (
    .clk     (clk),
    .rst     (rst),
    .busy    (busy),
    .alu_req (alu_req),
    .cdb     (cdb)
);

// File: source/ooo_backend_top.sv
// Out-of-order back end

`timescale 1ns/1ps

module ooo_backend_top #(
    parameter int NUM_PHYS_REGS = 64,
    parameter int MUL_STAGES    = 3
) (
    input  logic                         clk,
    input  logic                         rst,
    input  ooo_types_pkg::dispatch_req_t dispatch_req,
    output logic                         dispatch_busy,
    output ooo_types_pkg::cdb_t          cdb
);

    logic                      mark_valid;
    ooo_types_pkg::phys_tag_t  mark_rd;
    ooo_types_pkg::rob_id_t    mark_rob_id;
    ooo_types_pkg::phys_tag_t  rd_tag1;
    ooo_types_pkg::phys_tag_t  rd_tag2;
    ooo_types_pkg::operand_t   rd_data1;
    ooo_types_pkg::operand_t   rd_data2;
    ooo_types_pkg::exec_req_t  alu_req;
    ooo_types_pkg::exec_req_t  mul_req;
    ooo_types_pkg::cdb_slot_t  alu_cdb_slot;
    ooo_types_pkg::cdb_slot_t  mul_cdb_slot;

    assign cdb = '{alu_slot: alu_cdb_slot, mul_slot: mul_cdb_slot};

    dispatch_stage u_dispatch_stage (
        .clk         (clk),
        .rst         (rst),
        .req         (dispatch_req),
        .busy        (dispatch_busy),
        .mark_valid  (mark_valid),
        .mark_rd     (mark_rd),
        .mark_rob_id (mark_rob_id),
        .rd_tag1     (rd_tag1),
        .rd_tag2     (rd_tag2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .cdb         (cdb),
        .alu_req     (alu_req),
        .mul_req     (mul_req)
    );

    phys_reg_file #(
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_phys_reg_file (
        .clk         (clk),
        .rst         (rst),
        .mark_valid  (mark_valid),
        .mark_rd     (mark_rd),
        .mark_rob_id (mark_rob_id),
        .rd_tag1     (rd_tag1),
        .rd_tag2     (rd_tag2),
        .rd_data1    (rd_data1),
        .rd_data2    (rd_data2),
        .cdb         (cdb)
    );

    alu_unit u_alu_unit (
        .clk  (clk),
        .rst  (rst),
        .req  (alu_req),
        .slot (alu_cdb_slot)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul_unit (
        .clk  (clk),
        .rst  (rst),
        .req  (mul_req),
        .slot (mul_cdb_slot)
    );

endmodule

// File: source/mul_unit.sv
// Pipelined 32-bit multiplier

`timescale 1ns/1ps

module mul_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic                      clk,
    input  logic                      rst,
    input  ooo_types_pkg::exec_req_t  req,
    output ooo_types_pkg::cdb_slot_t  slot
);

    logic [MUL_STAGES-1:0]    valid_q;
    ooo_types_pkg::phys_tag_t rd_q [MUL_STAGES];
    ooo_types_pkg::rob_id_t   rob_q [MUL_STAGES];
    ooo_types_pkg::word_t     prod_q [1:MUL_STAGES-1];
    ooo_types_pkg::word_t     ll_d;
    ooo_types_pkg::word_t     ll_q;
    logic [15:0]              cross_d;
    logic [15:0]              cross_q;

    // Low half product plus the cross terms that land in bits 31:16
    assign ll_d    = 32'(req.a[15:0]) * 32'(req.b[15:0]);
    assign cross_d = req.a[15:0] * req.b[31:16] + req.a[31:16] * req.b[15:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[MUL_STAGES-2:0], req.valid};
        end
    end

    // Tags ride alongside the data so a new product can start every cycle
    always_ff @(posedge clk) begin
        rd_q[0]   <= req.rd;
        rob_q[0]  <= req.rob_id;
        ll_q      <= ll_d;
        cross_q   <= cross_d;
        prod_q[1] <= ll_q + {cross_q, 16'h0000};
        for (int s = 1; s < MUL_STAGES; s++) begin
            rd_q[s]  <= rd_q[s-1];
            rob_q[s] <= rob_q[s-1];
        end
        for (int s = 2; s < MUL_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    always_comb begin
        slot.valid  = valid_q[MUL_STAGES-1];
        slot.rd     = rd_q[MUL_STAGES-1];
        slot.rob_id = rob_q[MUL_STAGES-1];
        slot.value  = prod_q[MUL_STAGES-1];
    end

endmodule

// File: source/alu_unit.sv
// Single-cycle integer ALU

`timescale 1ns/1ps

module alu_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  ooo_types_pkg::exec_req_t  req,
    output ooo_types_pkg::cdb_slot_t  slot
);

    ooo_types_pkg::word_t result;

    always_comb begin
        case (req.op)
            ooo_types_pkg::OP_ADD: result = req.a + req.b;
            ooo_types_pkg::OP_SUB: result = req.a - req.b;
            ooo_types_pkg::OP_AND: result = req.a & req.b;
            ooo_types_pkg::OP_XOR: result = req.a ^ req.b;
            // Immediate arrives on operand b
            ooo_types_pkg::OP_LI:  result = req.b;
            default:               result = '0;
        endcase
    end

    // Result registered straight onto the ALU slot
    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= '0;
        end else begin
            slot.valid <= req.valid;
            if (req.valid) begin
                slot.rd     <= req.rd;
                slot.rob_id <= req.rob_id;
                slot.value  <= result;
            end
        end
    end

endmodule

// File: source/dispatch_stage.sv
// Dispatch hold stage

`timescale 1ns/1ps

module dispatch_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  ooo_types_pkg::dispatch_req_t req,
    output logic                         busy,
    output logic                         mark_valid,
    output ooo_types_pkg::phys_tag_t     mark_rd,
    output ooo_types_pkg::rob_id_t       mark_rob_id,
    output ooo_types_pkg::phys_tag_t     rd_tag1,
    output ooo_types_pkg::phys_tag_t     rd_tag2,
    input  ooo_types_pkg::operand_t      rd_data1,
    input  ooo_types_pkg::operand_t      rd_data2,
    input  ooo_types_pkg::cdb_t          cdb,
    output ooo_types_pkg::exec_req_t     alu_req,
    output ooo_types_pkg::exec_req_t     mul_req
);

    typedef enum logic {
        EMPTY,
        WAITING
    } state_t;

    state_t                       state_q;
    ooo_types_pkg::dispatch_req_t hold_q;
    ooo_types_pkg::exec_req_t     issue_q;
    ooo_types_pkg::phys_tag_t     src_tag [2];
    ooo_types_pkg::operand_t      rd_data [2];
    ooo_types_pkg::word_t         opnd_val_q [2];
    ooo_types_pkg::word_t         opnd_val_d [2];
    logic [1:0]                   opnd_rdy_q;
    logic [1:0]                   opnd_rdy_d;
    logic                         accept;
    logic                         fire;

    function automatic logic cdb_match(
        input ooo_types_pkg::cdb_slot_t slot,
        input ooo_types_pkg::phys_tag_t tag,
        input ooo_types_pkg::rob_id_t   rob_id
    );
        return slot.valid && (slot.rd == tag) && (slot.rob_id == rob_id);
    endfunction

    assign src_tag[0] = hold_q.rs1;
    assign src_tag[1] = hold_q.rs2;
    assign rd_tag1    = src_tag[0];
    assign rd_tag2    = src_tag[1];
    assign rd_data[0] = rd_data1;
    assign rd_data[1] = rd_data2;

    // Operand capture from the register read or a matching CDB slot
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            opnd_rdy_d[i] = opnd_rdy_q[i];
            opnd_val_d[i] = opnd_val_q[i];
            if (!opnd_rdy_q[i]) begin
                if (!rd_data[i].pending) begin
                    opnd_rdy_d[i] = 1'b1;
                    opnd_val_d[i] = rd_data[i].value;
                end else if (cdb_match(cdb.alu_slot, src_tag[i], rd_data[i].rob_id)) begin
                    opnd_rdy_d[i] = 1'b1;
                    opnd_val_d[i] = cdb.alu_slot.value;
                end else if (cdb_match(cdb.mul_slot, src_tag[i], rd_data[i].rob_id)) begin
                    opnd_rdy_d[i] = 1'b1;
                    opnd_val_d[i] = cdb.mul_slot.value;
                end
            end
        end
    end

    assign fire   = (state_q == WAITING) && (&opnd_rdy_d);
    assign busy   = (state_q == WAITING) && !fire;
    assign accept = req.valid && !busy;

    // Destination goes pending on the accepting edge
    assign mark_valid  = accept;
    assign mark_rd     = req.rd;
    assign mark_rob_id = req.rob_id;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= EMPTY;
            opnd_rdy_q <= '0;
            issue_q    <= '0;
        end else begin
            issue_q.valid <= fire;
            if (fire) begin
                issue_q.op     <= hold_q.op;
                issue_q.rd     <= hold_q.rd;
                issue_q.rob_id <= hold_q.rob_id;
                issue_q.a      <= opnd_val_d[0];
                issue_q.b      <= opnd_val_d[1];
            end
            if (accept) begin
                state_q <= WAITING;
                // LI has its immediate already and waits for nothing
                opnd_rdy_q <= (req.op == ooo_types_pkg::OP_LI) ? 2'b11 : 2'b00;
            end else begin
                if (fire) begin
                    state_q <= EMPTY;
                end
                opnd_rdy_q <= opnd_rdy_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold_q        <= req;
            opnd_val_q[0] <= '0;
            opnd_val_q[1] <= req.imm;
        end else begin
            opnd_val_q <= opnd_val_d;
        end
    end

    // Route by operation
    always_comb begin
        alu_req       = issue_q;
        mul_req       = issue_q;
        alu_req.valid = issue_q.valid && (issue_q.op != ooo_types_pkg::OP_MUL);
        mul_req.valid = issue_q.valid && (issue_q.op == ooo_types_pkg::OP_MUL);
    end

endmodule

// File: source/phys_reg_file.sv
// Physical register file
// Pending marks and CDB bypass

`timescale 1ns/1ps

module phys_reg_file #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mark_valid,
    input  ooo_types_pkg::phys_tag_t mark_rd,
    input  ooo_types_pkg::rob_id_t   mark_rob_id,
    input  ooo_types_pkg::phys_tag_t rd_tag1,
    input  ooo_types_pkg::phys_tag_t rd_tag2,
    output ooo_types_pkg::operand_t  rd_data1,
    output ooo_types_pkg::operand_t  rd_data2,
    input  ooo_types_pkg::cdb_t      cdb
);

    ooo_types_pkg::word_t   value_q [NUM_PHYS_REGS];
    ooo_types_pkg::rob_id_t rob_q [NUM_PHYS_REGS];
    logic [NUM_PHYS_REGS-1:0] pending_q;

    // A slot only counts for the renaming it was issued under
    function automatic logic slot_hits(input ooo_types_pkg::cdb_slot_t slot);
        return slot.valid && (slot.rd != '0) && (rob_q[slot.rd] == slot.rob_id);
    endfunction

    function automatic ooo_types_pkg::operand_t read_port(
        input ooo_types_pkg::phys_tag_t tag
    );
        ooo_types_pkg::operand_t res;
        res.value   = value_q[tag];
        res.pending = pending_q[tag];
        res.rob_id  = rob_q[tag];
        if (tag == '0) begin
            res = '0;
        end else if (slot_hits(cdb.alu_slot) && (cdb.alu_slot.rd == tag)) begin
            // ALU slot first when both units hit the same tag
            res.value   = cdb.alu_slot.value;
            res.pending = 1'b0;
        end else if (slot_hits(cdb.mul_slot) && (cdb.mul_slot.rd == tag)) begin
            res.value   = cdb.mul_slot.value;
            res.pending = 1'b0;
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= '0;
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                value_q[i] <= '0;
                rob_q[i]   <= '0;
            end
        end else begin
            if (slot_hits(cdb.alu_slot)) begin
                value_q[cdb.alu_slot.rd]   <= cdb.alu_slot.value;
                pending_q[cdb.alu_slot.rd] <= 1'b0;
            end
            if (slot_hits(cdb.mul_slot)) begin
                value_q[cdb.mul_slot.rd]   <= cdb.mul_slot.value;
                pending_q[cdb.mul_slot.rd] <= 1'b0;
            end
            // Mark comes last so it overrides a clear on the same tag
            if (mark_valid && (mark_rd != '0)) begin
                pending_q[mark_rd] <= 1'b1;
                rob_q[mark_rd]     <= mark_rob_id;
            end
        end
    end

    // Transparent reads so a result on the CDB is visible this cycle
    always_comb begin
        rd_data1 = read_port(rd_tag1);
        rd_data2 = read_port(rd_tag2);
    end

endmodule

// File: source/ooo_types_pkg.sv
// Back-end shared types
// Widths, operations and bus structs

package ooo_types_pkg;

    // Widths follow the default of 64 physical registers and an 8-entry ROB
    typedef logic [31:0] word_t;
    typedef logic [5:0]  phys_tag_t;
    typedef logic [2:0]  rob_id_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR,
        OP_LI,
        OP_MUL
    } op_t;

    // Renamed instruction from the front end
    typedef struct packed {
        logic      valid;
        op_t       op;
        phys_tag_t rs1;
        phys_tag_t rs2;
        phys_tag_t rd;
        rob_id_t   rob_id;
        word_t     imm;
    } dispatch_req_t;

    // One register file read result
    typedef struct packed {
        word_t   value;
        logic    pending;
        rob_id_t rob_id;
    } operand_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t rd;
        rob_id_t   rob_id;
        word_t     value;
    } cdb_slot_t;

    // One slot per execution unit
    typedef struct packed {
        cdb_slot_t alu_slot;
        cdb_slot_t mul_slot;
    } cdb_t;

    // Issued instruction with its operand values
    typedef struct packed {
        logic      valid;
        op_t       op;
        phys_tag_t rd;
        rob_id_t   rob_id;
        word_t     a;
        word_t     b;
    } exec_req_t;

endpackage
